// ==== filelist.f ====
+incdir+verif
hdl/prot_regs_pkg.sv
hdl/prot_math_pkg.sv
hdl/prot_reg_ctrl.sv
hdl/prot_divider.sv
hdl/prot_sqrt.sv
hdl/prot_collide.sv
hdl/prot_chip_top.sv
verif/prot_chip_tb.sv

// ==== Bender.yml ====
package:
  name: prot_chip

sources:
  - hdl/prot_regs_pkg.sv
  - hdl/prot_math_pkg.sv
  - hdl/prot_reg_ctrl.sv
  - hdl/prot_divider.sv
  - hdl/prot_sqrt.sv
  - hdl/prot_collide.sv
  - hdl/prot_chip_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/prot_chip_tb.sv

// ==== verif/prot_chip_ref.svh ====
/*
 * Reference models of the coprocessor results, taken from the register map rules.
 */

// a zero divisor gives an all ones quotient.
function automatic logic [15:0] ref_quot(input logic [15:0] a, input logic [15:0] b);
    return (b == 16'h0000) ? 16'hffff : a / b;
endfunction

// a zero divisor passes the dividend through as the remainder.
function automatic logic [15:0] ref_rem(input logic [15:0] a, input logic [15:0] b);
    return (b == 16'h0000) ? a : a % b;
endfunction

// floor root of op3 times 65536, found by halving an interval of candidates.
function automatic logic [15:0] ref_root(input logic [15:0] op3);
    longint lo;
    longint hi;
    longint mid;
    lo = 0;
    hi = 65535;
    while (lo < hi) begin
        mid = (lo + hi + 1) / 2; // rounds up so the interval always shrinks.
        if (mid * mid <= (longint'(op3) << 16)) begin
            lo = mid;
        end else begin
            hi = mid - 1;
        end
    end
    return 16'(lo);
endfunction

// both objects grow by the shared radius. The grown edges wrap at 16 bits.
function automatic logic ref_miss(input logic [15:0] rad, y1, x1, y2, x2);
    logic [15:0] x1_edge, x2_edge, y1_edge, y2_edge;
    x1_edge = x1 + rad;
    x2_edge = x2 + rad;
    y1_edge = y1 + rad;
    y2_edge = y2 + rad;
    return (x1_edge < x2) || (x2_edge < x1) || (y1_edge < y2) || (y2_edge < y1);
endfunction

function automatic logic [15:0] ref_xdiff(input logic [15:0] x1, input logic [15:0] x2);
    return x2 - x1; // a negative distance shows as a wrapped word.
endfunction

// the random byte is a running sum of the step register.
function automatic logic [7:0] ref_rng_next(input logic [7:0] cur, input logic [7:0] step);
    return cur + step;
endfunction

// ==== verif/prot_chip_tb.sv ====
/*
 * Testbench of the protection coprocessor. Drives the CPU byte port on the
 * falling clock edge and checks every result against the reference models.
 */
module prot_chip_tb
    import prot_regs_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    `include "prot_chip_ref.svh"

    localparam int clk_period = 20;
    localparam int div_wait   = 5;  // clocks from the last operand write to a valid read.
    localparam int sqrt_wait  = 35;
    localparam int coll_wait  = 3;
    // 141 iterations over all tests, each charged the root wait plus its bus clocks.
    localparam int watchdog_ns = (141 * (sqrt_wait + 16) + 500) * clk_period;
    // hand placed layouts as rad, yobj1, xobj1, yobj2, xobj2.
    localparam logic [0:3][0:4][15:0] placed = {
        {16'd10, 16'd200, 16'd100, 16'd200, 16'd110},      // edges touch, so no miss.
        {16'd10, 16'd200, 16'd100, 16'd200, 16'd111},      // one step apart in x.
        {16'd10, 16'd200, 16'd100, 16'd189, 16'd100},      // one step apart in y.
        {16'h0010, 16'h0000, 16'hfff8, 16'h0000, 16'h0004} // grown edge wraps past zero.
    };

    logic        clk, rst, cen, cs, wr_n;
    logic [4:0]  addr;
    logic [7:0]  din, dout;
    logic [7:0]  rd_data;           // dout as sampled by the last bus cycle.
    logic [7:0]  stored [32];       // bytes written by the register test.
    logic [7:0]  rng_model = 8'h00; // the random byte clears at reset.
    logic [15:0] a, b, q, r;
    logic [15:0] obj [5];
    integer      seed = 93708;
    int          errors = 0, checks = 0, tests = 0, err_base = 0;

    prot_chip_top dut (.clk(clk), .rst(rst), .cen(cen), .cs(cs), .wr_n(wr_n),
                       .addr(addr), .din(din), .dout(dout));

    always #(clk_period / 2) clk = ~clk;

    task automatic compare_value(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s expected %h got %h", name, exp, act);
        end
    endtask

    // one clock of bus activity, entered and left on a falling edge.
    task automatic bus_cycle(input logic [4:0] at, input logic [7:0] data,
                             input logic write, input logic sel, input logic en);
        addr = at;
        din  = data;
        wr_n = ~write;
        cs   = sel;
        cen  = en;
        @(negedge clk);
        rd_data = dout; // the byte chosen at the rising edge just passed.
        cs      = 1'b0;
        wr_n    = 1'b1;
    endtask

    task automatic write_word(input logic [4:0] at, input logic [15:0] w);
        bus_cycle(at, w[15:8], 1'b1, 1'b1, 1'b1); // big endian, high byte first.
        bus_cycle(at + 5'd1, w[7:0], 1'b1, 1'b1, 1'b1);
    endtask

    // waits out the result latency, then reads a word as two byte reads.
    task automatic read_word(input logic [4:0] at, input int wait_clocks,
                             output logic [15:0] w);
        repeat (wait_clocks) @(negedge clk);
        bus_cycle(at, 8'h00, 1'b0, 1'b1, 1'b1);
        w[15:8] = rd_data;
        bus_cycle(at + 5'd1, 8'h00, 1'b0, 1'b1, 1'b1);
        w[7:0] = rd_data;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %s done with %0d errors", name, errors - err_base);
        err_base = errors;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        {cen, cs, wr_n, addr, din} = {1'b0, 1'b0, 1'b1, 5'h00, 8'h00};
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // plain bytes, skipping the pair that reads back the x distance.
        for (int i = 8; i < 32; i++) begin
            stored[i] = 8'($random(seed));
            bus_cycle(5'(i), stored[i], 1'b1, 1'b1, 1'b1);
        end
        for (int i = 8; i < 32; i++) begin
            if (i != 14 && i != 15) begin
                bus_cycle(5'(i), 8'h00, 1'b0, 1'b1, 1'b1);
                compare_value($sformatf("dout at %0h", i), {8'h00, stored[i]}, {8'h00, rd_data});
            end
        end
        finish_test("registers");

        // every fifth divisor is zero and the rest shrink to give large quotients.
        for (int i = 0; i < 40; i++) begin
            a = 16'($random(seed));
            b = (i % 5 == 0) ? 16'h0000 : 16'($random(seed)) >> (i % 13);
            write_word(addr_op1_hi, a);
            write_word(addr_op2_hi, b);
            read_word(addr_op1_hi, div_wait, q);
            read_word(addr_op2_hi, 0, r);
            compare_value("quot", ref_quot(a, b), q);
            compare_value("rem", ref_rem(a, b), r);
        end
        finish_test("divide");

        for (int i = 0; i < 32; i++) begin
            a = (i == 0) ? 16'h0000 : (i == 1) ? 16'hffff : 16'($random(seed));
            write_word(addr_op3_hi, a);
            read_word(addr_op3_hi, sqrt_wait, q);
            compare_value("root", ref_root(a), q);
        end
        finish_test("sqrt");

        // the object words sit at 6, 8, 10, 12 and 14 in the order of obj.
        for (int i = 0; i < 24; i++) begin
            for (int k = 0; k < 5; k++) begin
                obj[k] = (i < 4) ? placed[i][k] : 16'($random(seed));
                write_word(5'(addr_rad_hi + 2 * k), obj[k]);
            end
            q = ref_miss(obj[0], obj[1], obj[2], obj[3], obj[4]) ? 16'h00ff : 16'h0000;
            repeat (coll_wait) @(negedge clk);
            bus_cycle(addr_rad_lo, 8'h00, 1'b0, 1'b1, 1'b1);
            compare_value("miss", q, {8'h00, rd_data});
            read_word(addr_xobj2_hi, 0, r);
            compare_value("xdiff", ref_xdiff(obj[2], obj[4]), r);
        end
        finish_test("collide");

        // a clock at address 6 with cs low shows the byte without stepping it.
        for (int i = 0; i < 20; i++) begin
            a[7:0] = 8'($random(seed));
            bus_cycle(addr_rng_step, a[7:0], 1'b1, 1'b1, 1'b1);
            bus_cycle(addr_rad_hi, 8'h00, 1'b0, 1'b0, 1'b1);
            compare_value("rng held", {8'h00, rng_model}, {8'h00, rd_data});
            bus_cycle(addr_rad_hi, 8'h00, 1'b0, 1'b1, 1'b1);
            rng_model = ref_rng_next(rng_model, a[7:0]);
            compare_value("rng", {8'h00, rng_model}, {8'h00, rd_data});
        end
        finish_test("random");

        write_word(addr_op1_hi, 16'h1234);
        write_word(addr_op2_hi, 16'h0011);
        bus_cycle(5'h10, 8'h5a, 1'b1, 1'b1, 1'b1);
        bus_cycle(5'h10, 8'ha5, 1'b1, 1'b1, 1'b0);       // cen low.
        bus_cycle(5'h10, 8'hc3, 1'b1, 1'b0, 1'b1);       // cs low.
        bus_cycle(addr_op1_lo, 8'hff, 1'b1, 1'b1, 1'b0); // would change the dividend.
        bus_cycle(addr_op2_lo, 8'h00, 1'b1, 1'b0, 1'b1); // would zero the divisor.
        bus_cycle(5'h10, 8'h00, 1'b0, 1'b1, 1'b1);
        compare_value("dout at 10", 16'h005a, {8'h00, rd_data});
        read_word(addr_op1_hi, div_wait, q);
        read_word(addr_op2_hi, 0, r);
        compare_value("quot", ref_quot(16'h1234, 16'h0011), q);
        compare_value("rem", ref_rem(16'h1234, 16'h0011), r);
        finish_test("strobes");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // stops a hung run once the longest possible test time has passed.
    initial begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== hdl/prot_chip_top.sv ====
/*
 * Protection and arithmetic coprocessor on an 8 bit CPU byte port.
 */
module prot_chip_top
    import prot_regs_pkg::*, prot_math_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       cs,
    input  logic       wr_n,
    input  logic [4:0] addr,
    input  logic [7:0] din,
    output logic [7:0] dout
);

    bus_req_t          req;
    operands_t         ops;
    results_t          res;
    logic              sqrt_start;
    logic [word_w-1:0] quot, rem, root, xdiff;
    logic              miss;

    // a bus cycle counts only when both strobes are up.
    assign req = '{addr: addr, wr: ~wr_n, din: din, access: cs & cen};
    assign res = '{quot: quot, rem: rem, root: root, xdiff: xdiff, miss: miss};

    prot_reg_ctrl u_reg_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .res        (res),
        .ops        (ops),
        .sqrt_start (sqrt_start),
        .dout       (dout)
    );

    prot_divider u_divider (.clk(clk), .rst(rst), .ops(ops), .quot(quot), .rem(rem));

    prot_sqrt u_sqrt (.clk(clk), .rst(rst), .start(sqrt_start), .ops(ops), .root(root));

    prot_collide u_collide (.clk(clk), .rst(rst), .ops(ops), .miss(miss), .xdiff(xdiff));

endmodule

// ==== hdl/prot_collide.sv ====
/*
 * Rectangle overlap test of two objects sharing one radius, plus their x distance.
 */
module prot_collide
    import prot_math_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  operands_t         ops,
    output logic              miss,
    output logic [word_w-1:0] xdiff
);

    logic [word_w-1:0] xrad1, yrad1, xrad2, yrad2; // edges grown by the radius.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            xrad1 <= '0;
            yrad1 <= '0;
            xrad2 <= '0;
            yrad2 <= '0;
            xdiff <= '0;
            miss  <= 1'b0;
        end else begin
            xrad1 <= ops.xobj1 + ops.rad; // sums wrap at 16 bits.
            yrad1 <= ops.yobj1 + ops.rad;
            xrad2 <= ops.xobj2 + ops.rad;
            yrad2 <= ops.yobj2 + ops.rad;
            xdiff <= ops.xobj2 - ops.xobj1;
            // any object lying wholly past the other's grown edge is a miss.
            miss  <= (xrad1 < ops.xobj2) || (xrad2 < ops.xobj1) ||
                     (yrad1 < ops.yobj2) || (yrad2 < ops.yobj1);
        end
    end

endmodule

// ==== hdl/prot_sqrt.sv ====
/*
 * Bit serial square root of op3 as a 16.16 value, two clocks per root bit.
 */
module prot_sqrt
    import prot_math_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  operands_t         ops,
    output logic [word_w-1:0] root
);

    sqrt_state_e                   state;
    logic [word_w-1:0]             target;  // op3 captured at start.
    logic [$clog2(sqrt_steps)-1:0] bit_idx; // root bit under trial.
    logic [2*word_w-1:0]           square;  // trial value squared.
    logic [word_w-1:0]             trial;

    // the kept bits plus the bit being tried.
    assign trial = root | (word_w'(1) << bit_idx);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= sq_idle;
            root    <= '0;
            target  <= '0;
            bit_idx <= '0;
            square  <= '0;
        end else if (start) begin
            // a new start wins over any search in flight.
            state   <= sq_square;
            root    <= '0;
            target  <= ops.op3;
            bit_idx <= $bits(bit_idx)'(sqrt_steps - 1);
        end else begin
            case (state)
                sq_square: begin
                    square <= trial * trial; // full 32 bit product.
                    state  <= sq_decide;
                end
                sq_decide: begin
                    // keep the bit while the square stays within op3 times 65536.
                    if (square <= {target, {word_w{1'b0}}}) begin
                        root <= trial;
                    end
                    if (bit_idx == '0) begin
                        state <= sq_done;
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                        state   <= sq_square;
                    end
                end
                sq_done: state <= sq_idle; // root holds until the next start.
                default: state <= sq_idle;
            endcase
        end
    end

endmodule

// ==== hdl/prot_divider.sv ====
/*
 * Three stage unsigned 16 bit divider giving quotient and remainder.
 */
module prot_divider
    import prot_math_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  operands_t         ops,
    output logic [word_w-1:0] quot,
    output logic [word_w-1:0] rem
);

    logic [word_w-1:0] quot_s1, op1_s1, op2_s1; // after the divide.
    logic [word_w-1:0] quot_s2, op1_s2, prod_s2; // after the multiply back.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            quot_s1 <= '0;
            op1_s1  <= '0;
            op2_s1  <= '0;
            quot_s2 <= '0;
            op1_s2  <= '0;
            prod_s2 <= '0;
            quot    <= '0;
            rem     <= '0;
        end else begin
            // a zero divisor gives an all ones quotient.
            quot_s1 <= (ops.op2 == '0) ? '1 : ops.op1 / ops.op2;
            op1_s1  <= ops.op1;
            op2_s1  <= ops.op2;
            prod_s2 <= quot_s1 * op2_s1; // never exceeds op1, so no bits are lost.
            quot_s2 <= quot_s1;
            op1_s2  <= op1_s1;
            quot    <= quot_s2;
            rem     <= op1_s2 - prod_s2; // equals op1 when the divisor was zero.
        end
    end

endmodule

// ==== hdl/prot_reg_ctrl.sv ====
/*
 * Register window of the protection coprocessor. Holds the operand bytes,
 * starts the root search, steps the random byte and drives the read data.
 */
module prot_reg_ctrl
    import prot_regs_pkg::*, prot_math_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  bus_req_t   req,
    input  results_t   res,
    output operands_t  ops,
    output logic       sqrt_start,
    output logic [7:0] dout
);

    logic [7:0] mem [reg_count]; // byte registers.
    logic [7:0] rng;             // current random byte.
    logic [7:0] next_rng;
    logic       wr_en;
    logic       rd_en;
    reg_addr_e  sel;

    assign sel      = reg_addr_e'(req.addr);
    assign wr_en    = req.access & req.wr;
    assign rd_en    = req.access & ~req.wr;
    assign next_rng = rng + mem[addr_rng_step]; // wraps at eight bits.

    // operand words are plain concatenations of the stored bytes.
    always_comb begin
        ops.op1   = {mem[addr_op1_hi], mem[addr_op1_lo]};
        ops.op2   = {mem[addr_op2_hi], mem[addr_op2_lo]};
        ops.op3   = {mem[addr_op3_hi], mem[addr_op3_lo]};
        ops.rad   = {mem[addr_rad_hi], mem[addr_rad_lo]};
        ops.yobj1 = {mem[addr_yobj1_hi], mem[addr_yobj1_lo]};
        ops.xobj1 = {mem[addr_xobj1_hi], mem[addr_xobj1_lo]};
        ops.yobj2 = {mem[addr_yobj2_hi], mem[addr_yobj2_lo]};
        ops.xobj2 = {mem[addr_xobj2_hi], mem[addr_xobj2_lo]};
    end

    // the byte store itself holds whatever the CPU last wrote.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[req.addr] <= req.din;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sqrt_start <= 1'b0;
            rng        <= 8'h00;
            dout       <= 8'h00;
        end else begin
            // a write to either byte of op3 restarts the root search.
            sqrt_start <= wr_en && (sel == addr_op3_hi || sel == addr_op3_lo);

            if (rd_en && sel == addr_rad_hi) begin
                rng <= next_rng; // only a real read consumes a random value.
            end

            // read data follows the address on every clock.
            case (sel)
                addr_op1_hi:   dout <= res.quot[15:8];
                addr_op1_lo:   dout <= res.quot[7:0];
                addr_op2_hi:   dout <= res.rem[15:8];
                addr_op2_lo:   dout <= res.rem[7:0];
                addr_op3_hi:   dout <= res.root[15:8];
                addr_op3_lo:   dout <= res.root[7:0];
                addr_rad_hi:   dout <= rd_en ? next_rng : rng; // new value shows at once.
                addr_rad_lo:   dout <= {8{res.miss}};          // flag reads as ff or 00.
                addr_xobj2_hi: dout <= res.xdiff[15:8];
                addr_xobj2_lo: dout <= res.xdiff[7:0];
                default:       dout <= mem[req.addr];
            endcase
        end
    end

endmodule

// ==== hdl/prot_math_pkg.sv ====
/*
 * Arithmetic datapath types of the protection coprocessor.
 */
package prot_math_pkg;

    localparam int word_w     = 16; // width of every operand and result word.
    localparam int sqrt_steps = 16; // root bits resolved by the search.

    // operand words as the register file presents them.
    typedef struct packed {
        logic [word_w-1:0] op1;   // dividend.
        logic [word_w-1:0] op2;   // divisor.
        logic [word_w-1:0] op3;   // square root input, integer part of a 16.16 value.
        logic [word_w-1:0] rad;   // collision radius shared by both objects.
        logic [word_w-1:0] yobj1;
        logic [word_w-1:0] xobj1;
        logic [word_w-1:0] yobj2;
        logic [word_w-1:0] xobj2;
    } operands_t;

    // result levels read back by the CPU.
    typedef struct packed {
        logic [word_w-1:0] quot;
        logic [word_w-1:0] rem;
        logic [word_w-1:0] root;
        logic [word_w-1:0] xdiff; // xobj2 minus xobj1.
        logic              miss;  // rectangles do not overlap.
    } results_t;

    // the root search alternates between squaring a trial and judging it.
    typedef enum logic [1:0] {
        sq_idle,
        sq_square,
        sq_decide,
        sq_done
    } sqrt_state_e;

endpackage

// ==== hdl/prot_regs_pkg.sv ====
/*
 * Protection coprocessor register map and the request word of its CPU byte port.
 */
package prot_regs_pkg;

    localparam int reg_count  = 32; // byte registers in the CPU window.
    localparam int reg_addr_w = 5;  // address bits needed to pick one of them.

    // operands are big endian, so the high byte sits at the even address.
    // reads of the low addresses return results rather than the stored byte.
    typedef enum logic [reg_addr_w-1:0] {
        addr_op1_hi   = 5'h00, // quotient high byte on read.
        addr_op1_lo   = 5'h01, // quotient low byte on read.
        addr_op2_hi   = 5'h02, // remainder high byte on read.
        addr_op2_lo   = 5'h03, // remainder low byte on read.
        addr_op3_hi   = 5'h04, // root high byte on read.
        addr_op3_lo   = 5'h05, // root low byte on read.
        addr_rad_hi   = 5'h06, // random byte on read.
        addr_rad_lo   = 5'h07, // miss flag on read.
        addr_yobj1_hi = 5'h08,
        addr_yobj1_lo = 5'h09,
        addr_xobj1_hi = 5'h0a,
        addr_xobj1_lo = 5'h0b,
        addr_yobj2_hi = 5'h0c,
        addr_yobj2_lo = 5'h0d,
        addr_xobj2_hi = 5'h0e, // x distance high byte on read.
        addr_xobj2_lo = 5'h0f, // x distance low byte on read.
        addr_rng_step = 5'h13  // increment added to the random byte.
    } reg_addr_e;

    // one bus cycle as seen on a clock edge.
    typedef struct packed {
        logic [reg_addr_w-1:0] addr;   // byte address.
        logic                  wr;     // high for a write, low for a read.
        logic [7:0]            din;    // write data.
        logic                  access; // chip select and clock enable both high.
    } bus_req_t;

endpackage
